// File: dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// ---------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------
`define DMA_ADDR_W 16 // Word address, byte address has one more bit
`define DMA_DATA_W 16 // One memory word

// ---------------------------------------------------------------------
// Internal buffer
// ---------------------------------------------------------------------
`define DMA_FIFO_AW 3 // Pointer bits
// Capacity, also the longest accepted request
`define DMA_FIFO_WORDS (1 << `DMA_FIFO_AW)

`endif

// File: dma_bus_pkg.sv
`default_nettype none

`include "dma_cfg.svh"

// Types seen on the device and memory buses
package dma_bus_pkg;

	// Memory word address
	typedef logic [`DMA_ADDR_W-1:0] addr_t;

	// Byte start address from the device
	typedef logic [`DMA_ADDR_W:0] byte_addr_t;

	// Data word, same on both sides
	typedef logic [`DMA_DATA_W-1:0] word_t;

	// Requested word count
	typedef logic [`DMA_ADDR_W-1:0] count_t;

endpackage

`default_nettype wire

// File: dma_ctrl_pkg.sv
`default_nettype none

// Control encodings shared by capture, sequencer and memory port
package dma_ctrl_pkg;

	// Class of a latched request
	typedef enum logic [1:0] {
		REQ_READ,     // Memory to device
		REQ_WRITE,    // Device to memory
		REQ_EMPTY,    // Zero words
		REQ_TOO_LONG  // Does not fit the buffer
	} req_kind_t;

	// Transfer sequencer states
	typedef enum logic [2:0] {
		IDLE,
		START,     // Flush buffer, clear counter
		COLLECT,   // Device words into FIFO
		MEM_WRITE, // FIFO to memory
		MEM_READ,  // Memory into FIFO
		DELIVER,   // FIFO to device
		DONE,
		FAIL
	} seq_state_t;

	// Memory write strobe codes
	typedef enum logic [1:0] {
		WE_NONE = 2'b00,
		WE_WORD = 2'b11  // Both bytes
	} we_t;

endpackage

`default_nettype wire

// File: dma_req_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_req_capture
	import dma_bus_pkg::*, dma_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  logic       rqst,
	input  logic       rd_wr,
	input  count_t     num_words,
	input  byte_addr_t start_addr,
	input  logic       busy,
	output logic       req_strobe,
	output req_kind_t  req_kind,
	output count_t     word_count,
	output addr_t      base_addr
);

	logic      take; // Request accepted this cycle
	req_kind_t kind_in;

	assign take = rqst && !busy;

	// Classify on the raw inputs
	always_comb
	begin
		if (num_words == '0)
			kind_in = REQ_EMPTY;
		else if (num_words > count_t'(`DMA_FIFO_WORDS))
			kind_in = REQ_TOO_LONG; // No splitting
		else if (rd_wr)
			kind_in = REQ_READ;
		else
			kind_in = REQ_WRITE;
	end

	// Strobe and class
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			req_strobe <= 1'b0;
			req_kind   <= REQ_EMPTY;
		end
		else
		begin
			req_strobe <= take; // One cycle after rqst
			if (take)
				req_kind <= kind_in;
		end
	end

	// Count and word address, held for the whole transfer
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			word_count <= num_words;
			base_addr  <= start_addr[`DMA_ADDR_W:1]; // Byte to word address
		end
	end

endmodule

`default_nettype wire

// File: dma_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_fifo
	import dma_bus_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	input  logic  push,
	input  logic  pop,
	input  logic  flush,
	input  word_t din,
	output word_t head,
	output logic  empty
);

	word_t                  mem [`DMA_FIFO_WORDS];
	logic [`DMA_FIFO_AW-1:0] wr_ptr;
	logic [`DMA_FIFO_AW-1:0] rd_ptr;
	logic [`DMA_FIFO_AW:0]   fill; // One extra bit for full
	logic                    full;
	logic                    do_push;
	logic                    do_pop;

	assign empty = (fill == '0);
	assign full  = (fill == (`DMA_FIFO_AW+1)'(`DMA_FIFO_WORDS));

	// A pop frees the slot for a push in the same cycle
	assign do_push = push && (!full || pop);
	assign do_pop  = pop && !empty;

	assign head = mem[rd_ptr]; // Valid one cycle after the push

	// ---------------------------------------------------------------------
	// Pointers and fill level
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else if (flush) // Overrides push and pop
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at capacity
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				fill <= fill + 1'b1;
			else if (do_pop && !do_push)
				fill <= fill - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push && !flush)
			mem[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

// File: dma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_sequencer
	import dma_bus_pkg::*, dma_ctrl_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  logic      req_strobe,
	input  req_kind_t req_kind,
	input  count_t    word_count,
	input  logic      dev_ack,
	input  logic      mem_done,
	input  logic      dma_resp_err,
	input  logic      fifo_empty,
	output logic      busy,
	output logic      mem_run,
	output logic      mem_write,
	output logic      dev_push,
	output logic      dev_pop,
	output logic      flush,
	output logic      dma_ack,
	output logic      end_flag,
	output logic      error_flag
);

	seq_state_t            state;
	seq_state_t            next_state;
	logic [`DMA_FIFO_AW:0] dev_cnt;      // Words taken from the device
	logic [`DMA_FIFO_AW:0] dev_cnt_next;
	logic                  last_word;    // Final word of COLLECT

	// Count never exceeds the buffer, low bits are exact
	assign dev_cnt_next = dev_cnt + 1'b1;
	assign last_word    = (dev_cnt_next == word_count[`DMA_FIFO_AW:0]);

	// Strobe pending counts as busy too
	assign busy = (state != IDLE) || req_strobe;

	// ---------------------------------------------------------------------
	// State register and device counter
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= IDLE;
			dev_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == START)
				dev_cnt <= '0;
			else if (state == COLLECT && dev_ack)
				dev_cnt <= dev_cnt_next;
		end
	end

	// Next state
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (req_strobe)
				begin
					case (req_kind)
						REQ_EMPTY:    next_state = DONE; // Nothing to move
						REQ_TOO_LONG: next_state = FAIL;
						default:      next_state = START;
					endcase
				end
			START:
				next_state = (req_kind == REQ_READ) ? MEM_READ : COLLECT;
			COLLECT:
				if (dev_ack && last_word)
					next_state = MEM_WRITE;
			MEM_WRITE:
				if (dma_resp_err)
					next_state = FAIL; // Error wins over done
				else if (mem_done)
					next_state = DONE;
			MEM_READ:
				if (dma_resp_err)
					next_state = FAIL;
				else if (mem_done)
					next_state = DELIVER; // Last word already pushed
			DELIVER:
				if (fifo_empty)
					next_state = DONE;
			DONE:
				next_state = IDLE;
			FAIL:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	// ---------------------------------------------------------------------
	// Outputs, decoded from state
	// ---------------------------------------------------------------------
	always_comb
	begin
		mem_run    = 1'b0;
		mem_write  = 1'b0;
		dev_push   = 1'b0;
		dev_pop    = 1'b0;
		flush      = 1'b0;
		dma_ack    = 1'b0;
		end_flag   = 1'b0;
		error_flag = 1'b0;
		case (state)
			START:
				flush = 1'b1; // Drop leftovers
			COLLECT:
			begin
				dev_push = dev_ack; // Take dev_in
				dma_ack  = dev_ack;
			end
			MEM_WRITE:
			begin
				mem_run   = 1'b1;
				mem_write = 1'b1;
			end
			MEM_READ:
				mem_run = 1'b1;
			DELIVER:
			begin
				dev_pop = dev_ack && !fifo_empty; // Head shown on dev_out
				dma_ack = dev_ack && !fifo_empty;
			end
			DONE:
				end_flag = 1'b1;
			FAIL:
			begin
				error_flag = 1'b1;
				flush      = 1'b1; // Also kills a late read response
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: dma_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_mem_port
	import dma_bus_pkg::*, dma_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  logic       mem_run,
	input  logic       mem_write,
	input  addr_t      base_addr,
	input  count_t     word_count,
	input  logic       dma_ready,
	input  logic       dma_resp,
	input  word_t      dma_in,
	output addr_t      dma_addr,
	output logic       dma_en,
	output logic [1:0] dma_we,
	output logic       mem_pop,
	output logic       rsp_push,
	output word_t      rsp_data,
	output logic       mem_done,
	output logic       dma_resp_err
);

	logic [`DMA_FIFO_AW:0] beat_cnt;   // Accepted beats so far
	logic [`DMA_FIFO_AW:0] beat_total;
	logic                  beats_left;
	logic                  accept;     // Beat taken by memory
	logic                  rsp_pend;   // Read data due this cycle

	assign beat_total = word_count[`DMA_FIFO_AW:0];
	assign beats_left = (beat_cnt != beat_total);

	// Bus drive
	assign dma_en = mem_run && beats_left;
	assign dma_we = (dma_en && mem_write) ? WE_WORD : WE_NONE;
	// Index only moves on accept, so address holds under stall
	assign dma_addr = base_addr + {{(`DMA_ADDR_W-`DMA_FIFO_AW-1){1'b0}}, beat_cnt};

	assign accept       = dma_en && dma_ready;
	assign dma_resp_err = dma_resp && dma_en; // Ignored outside beats

	// Write side pops on accept, head then moves to the next word
	assign mem_pop = accept && mem_write;

	// Read side pushes the response one cycle later
	assign rsp_push = rsp_pend;
	assign rsp_data = dma_in;

	// Write ends on final accept, read ends on final response
	always_comb
	begin
		if (mem_write)
			mem_done = accept && ((beat_cnt + 1'b1) == beat_total);
		else
			mem_done = rsp_pend && !beats_left;
	end

	// ---------------------------------------------------------------------
	// Beat counter and response flag
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			beat_cnt <= '0;
			rsp_pend <= 1'b0;
		end
		else
		begin
			if (!mem_run)
				beat_cnt <= '0; // Ready for the next phase
			else if (accept)
				beat_cnt <= beat_cnt + 1'b1;
			rsp_pend <= accept && !mem_write; // One deep
		end
	end

endmodule

`default_nettype wire

// File: dma_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_controller
	import dma_bus_pkg::*, dma_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	// Device side
	input  logic       rqst,
	input  logic       rd_wr,
	input  count_t     num_words,
	input  byte_addr_t start_addr,
	input  logic       dev_ack,
	input  word_t      dev_in,
	output logic       dma_ack,
	output word_t      dev_out,
	output logic       end_flag,
	output logic       error_flag,
	// Memory side
	input  word_t      dma_in,
	input  logic       dma_ready,
	input  logic       dma_resp,
	output addr_t      dma_addr,
	output word_t      dma_out,
	output logic       dma_en,
	output logic [1:0] dma_we
);

	// Capture to sequencer and memory port
	logic      req_strobe;
	req_kind_t req_kind;
	count_t    word_count;
	addr_t     base_addr;
	logic      busy;
	// Sequencer and memory port
	logic      mem_run;
	logic      mem_write;
	logic      mem_done;
	logic      dma_resp_err;
	// FIFO controls
	logic      dev_push;
	logic      dev_pop;
	logic      mem_pop;
	logic      rsp_push;
	logic      flush;
	logic      fifo_push;
	logic      fifo_pop;
	logic      fifo_empty;
	word_t     rsp_data;
	word_t     fifo_din;
	word_t     head;

	// Only one side pushes or pops in any state
	assign fifo_push = dev_push | rsp_push;
	assign fifo_pop  = dev_pop | mem_pop;
	assign fifo_din  = dev_push ? dev_in : rsp_data;

	// Head feeds both directions
	assign dev_out = head;
	assign dma_out = head;

	dma_req_capture i_capture (
		.clk        (clk),
		.reset      (reset),
		.rqst       (rqst),
		.rd_wr      (rd_wr),
		.num_words  (num_words),
		.start_addr (start_addr),
		.busy       (busy),
		.req_strobe (req_strobe),
		.req_kind   (req_kind),
		.word_count (word_count),
		.base_addr  (base_addr)
	);

	dma_sequencer i_sequencer (
		.clk          (clk),
		.reset        (reset),
		.req_strobe   (req_strobe),
		.req_kind     (req_kind),
		.word_count   (word_count),
		.dev_ack      (dev_ack),
		.mem_done     (mem_done),
		.dma_resp_err (dma_resp_err),
		.fifo_empty   (fifo_empty),
		.busy         (busy),
		.mem_run      (mem_run),
		.mem_write    (mem_write),
		.dev_push     (dev_push),
		.dev_pop      (dev_pop),
		.flush        (flush),
		.dma_ack      (dma_ack),
		.end_flag     (end_flag),
		.error_flag   (error_flag)
	);

	dma_fifo i_fifo (
		.clk   (clk),
		.reset (reset),
		.push  (fifo_push),
		.pop   (fifo_pop),
		.flush (flush),
		.din   (fifo_din),
		.head  (head),
		.empty (fifo_empty)
	);

	dma_mem_port i_mem_port (
		.clk          (clk),
		.reset        (reset),
		.mem_run      (mem_run),
		.mem_write    (mem_write),
		.base_addr    (base_addr),
		.word_count   (word_count),
		.dma_ready    (dma_ready),
		.dma_resp     (dma_resp),
		.dma_in       (dma_in),
		.dma_addr     (dma_addr),
		.dma_en       (dma_en),
		.dma_we       (dma_we),
		.mem_pop      (mem_pop),
		.rsp_push     (rsp_push),
		.rsp_data     (rsp_data),
		.mem_done     (mem_done),
		.dma_resp_err (dma_resp_err)
	);

endmodule

`default_nettype wire

// File: dma_controller_props.sv
`timescale 1ns/1ps
`default_nettype none

// Port-level rules of the DMA controller, bound onto dma_controller
module dma_controller_props
	import dma_bus_pkg::*;
(
	input wire        clk,
	input wire        reset,
	input logic       dma_en,
	input logic       dma_ready,
	input logic       dma_resp,
	input addr_t      dma_addr,
	input logic [1:0] dma_we,
	input word_t      dma_out,
	input logic       dma_ack,
	input logic       end_flag,
	input logic       error_flag
);

	int prop_fails = 0; // Failed assertions so far

	// ---------------------------------------------------------------------
	// Reset values
	// ---------------------------------------------------------------------
	assert property (@(posedge clk)
		reset |-> (!dma_en && dma_we == 2'b00 && !dma_ack && !end_flag && !error_flag))
	else
	begin
		$error("control output high while in reset");
		prop_fails++;
	end

	// Back-pressure, an error response ends the beat instead
	// Read beats carry no data on dma_out
	assert property (@(posedge clk) disable iff (reset)
		(dma_en && !dma_ready && !dma_resp) |=>
			($stable(dma_addr) && $stable(dma_we) && (dma_we == 2'b00 || $stable(dma_out))))
	else
	begin
		$error("memory beat changed while stalled");
		prop_fails++;
	end

	assert property (@(posedge clk) disable iff (reset) !(end_flag && error_flag))
	else
	begin
		$error("end_flag and error_flag high together");
		prop_fails++;
	end

	assert property (@(posedge clk) disable iff (reset) (dma_we != 2'b00) |-> dma_en)
	else
	begin
		$error("write strobe without enable");
		prop_fails++;
	end

endmodule

`default_nettype wire

// File: tb_dma_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module tb_dma_controller
	import dma_bus_pkg::*;
();

	localparam int NUM_OPS    = 12;
	localparam int WAIT_LIMIT = 300; // Cycles per operation

	// One table row
	typedef struct packed {
		logic       rd;       // 1 = memory to device
		byte_addr_t addr;     // Byte start address
		count_t     n;        // Word count
		logic       stall;    // Random ready and ack
		int         err_beat; // Beat with dma_resp, -1 none
	} op_t;

	op_t ops [NUM_OPS] = '{
		'{1'b0, 17'h00100, 16'd5, 1'b0, -1}, // Write, then read it back
		'{1'b1, 17'h00100, 16'd5, 1'b0, -1},
		'{1'b1, 17'h00451, 16'd8, 1'b0, -1}, // Odd byte address, full buffer
		'{1'b0, 17'h00200, 16'd8, 1'b1, -1}, // Stalled pair
		'{1'b1, 17'h00200, 16'd8, 1'b1, -1},
		'{1'b0, 17'h00301, 16'd3, 1'b1, -1},
		'{1'b1, 17'h00602, 16'd7, 1'b1, -1},
		'{1'b0, 17'h00700, 16'd0, 1'b0, -1}, // Zero length
		'{1'b1, 17'h00700, 16'd9, 1'b0, -1}, // One word too long
		'{1'b0, 17'h00800, 16'd6, 1'b0, 2},  // Write error, then clean write
		'{1'b0, 17'h00800, 16'd6, 1'b0, -1},
		'{1'b1, 17'h00a00, 16'd5, 1'b0, 3}   // Read error
	};

	logic       clk;
	logic       reset;
	logic       rqst;
	logic       rd_wr;
	count_t     num_words;
	byte_addr_t start_addr;
	logic       dev_ack;
	word_t      dev_in;
	logic       dma_ack;
	word_t      dev_out;
	logic       end_flag;
	logic       error_flag;
	word_t      dma_in;
	logic       dma_ready;
	logic       dma_resp;
	addr_t      dma_addr;
	word_t      dma_out;
	logic       dma_en;
	logic [1:0] dma_we;

	word_t       mem [0:65535]; // Memory model
	word_t       rd_data;       // Data for the next cycle
	word_t       taken [$];     // Device words on dma_ack
	word_t       got [$];       // dev_out words on dma_ack
	logic [31:0] lfsr = 32'hc365;
	logic        cur_rd = 1'b0;
	logic        cur_stall = 1'b0;
	int          cur_err = -1;
	addr_t       exp_base = '0;
	int          beats, acks, ends, errs, en_cycles;
	int          dev_seq = 0;
	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;

	dma_controller i_dut (.*);

	bind dma_controller dma_controller_props i_props (.*);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Byte swap keeps every address bit in the word
	function automatic word_t fill_word(input int a);
		return word_t'({a[7:0], a[15:8]} ^ 16'h5aa5);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] val,
		input logic [31:0] exp);
		checks++;
		assert (val === exp)
		else
		begin
			$display("ERROR: %s got %h expected %h", name, val, exp);
			errors++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ---------------------------------------------------------------------
	// Memory and device models
	// ---------------------------------------------------------------------
	always @(posedge clk)
	begin
		#1;
		if (cur_stall)
		begin
			lfsr      = lfsr_step(lfsr);
			dma_ready = lfsr[0];
			lfsr      = lfsr_step(lfsr);
			dev_ack   = lfsr[0];
		end
		else
		begin
			dma_ready = 1'b1;
			dev_ack   = 1'b1;
		end
		dma_resp = (cur_err >= 0) && (beats == cur_err); // Chosen beat only
		dma_in   = rd_data; // Read of the previous cycle
		dev_in   = word_t'(16'h1000 + dev_seq * 16'h0123);
	end

	// Sampled mid-cycle, all settled
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (dma_en)
				en_cycles++;
			if (dma_en && dma_ready)
			begin
				compare_value("dma_addr", dma_addr, addr_t'(exp_base + addr_t'(beats)));
				compare_value("dma_we", dma_we, cur_rd ? 2'b00 : 2'b11);
				if (cur_rd)
					rd_data = mem[dma_addr];
				else
					mem[dma_addr] = dma_out;
				beats++;
			end
			if (dma_ack)
			begin
				acks++;
				if (cur_rd)
					got.push_back(dev_out);
				else
				begin
					taken.push_back(dev_in);
					dev_seq++; // Next device word
				end
			end
			if (end_flag)
				ends++;
			if (error_flag)
				errs++;
		end
	end

	// ---------------------------------------------------------------------
	// One table entry: request, wait, check
	// ---------------------------------------------------------------------
	task automatic run_op(input int idx);
		op_t op;
		int  waited;
		op        = ops[idx];
		cur_rd    = op.rd;
		cur_stall = op.stall;
		cur_err   = op.err_beat;
		exp_base  = op.addr[`DMA_ADDR_W:1];
		beats     = 0;
		acks      = 0;
		ends      = 0;
		errs      = 0;
		en_cycles = 0;
		taken.delete();
		got.delete();
		@(posedge clk);
		#1;
		rqst       = 1'b1;
		rd_wr      = op.rd;
		num_words  = op.n;
		start_addr = op.addr;
		@(posedge clk);
		#1;
		rqst   = 1'b0;
		waited = 0;
		while (ends == 0 && errs == 0 && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (ends == 0 && errs == 0)
		begin
			$display("Operation %0d timed out with no end_flag or error_flag", idx);
			timeouts++;
		end
		repeat (4) @(posedge clk); // Catch a second pulse

		if (op.n == 0)
		begin
			compare_value("end_flag", ends, 1);
			compare_value("error_flag", errs, 0);
			compare_value("dma_en", en_cycles, 0);
			compare_value("dma_ack", acks, 0);
		end
		else if (op.n > `DMA_FIFO_WORDS)
		begin
			compare_value("error_flag", errs, 1);
			compare_value("end_flag", ends, 0);
			compare_value("dma_en", en_cycles, 0);
		end
		else if (op.err_beat >= 0)
		begin
			compare_value("error_flag", errs, 1); // Abort, no completion
			compare_value("end_flag", ends, 0);
		end
		else
		begin
			compare_value("end_flag", ends, 1);
			compare_value("error_flag", errs, 0);
			compare_value("memory beats", beats, op.n);
			compare_value("dma_ack", acks, op.n);
			if (op.rd)
			begin
				compare_value("dev_out words", got.size(), op.n);
				for (int i = 0; i < got.size() && i < op.n; i++)
					compare_value("dev_out", got[i], mem[addr_t'(exp_base + addr_t'(i))]);
			end
			else
			begin
				compare_value("dev_in words", taken.size(), op.n);
				for (int i = 0; i < taken.size() && i < op.n; i++)
					compare_value("dma_out", mem[addr_t'(exp_base + addr_t'(i))], taken[i]);
			end
		end
	endtask

	initial
	begin
		reset      = 1'b1;
		rqst       = 1'b0;
		rd_wr      = 1'b0;
		num_words  = '0;
		start_addr = '0;
		dev_ack    = 1'b0;
		dev_in     = '0;
		dma_in     = '0;
		dma_ready  = 1'b0;
		dma_resp   = 1'b0;
		rd_data    = '0;
		for (int a = 0; a < 65536; a++)
			mem[a] = fill_word(a);
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < NUM_OPS; i++)
			run_op(i);
		$display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, i_dut.i_props.prop_fails);
		if (errors == 0 && timeouts == 0 && i_dut.i_props.prop_fails == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
dma_bus_pkg.sv
dma_ctrl_pkg.sv
dma_req_capture.sv
dma_fifo.sv
dma_sequencer.sv
dma_mem_port.sv
dma_controller.sv
dma_controller_props.sv
tb_dma_controller.sv
